// File: Makefile
# Verilator lint, simulation and cleanup for the ethernet frame mux

TB_TOP := tb_eth_mux_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f eth_mux_top.f --top-module eth_mux_top

sim:
	verilator --binary --timing -f eth_mux_top.f --top-module $(TB_TOP) \
		-Mdir obj_dir -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: common/eth_hdr_pkg.sv
// ethernet header field widths, header struct and port index type
`default_nettype none

package eth_hdr_pkg;

    // destination and source MAC address width
    localparam int MAC_W = 48;

    // ethertype / length field width
    localparam int TYPE_W = 16;

    // one header transfer, 112 bits, dest_mac in the upper bits
    typedef struct packed {
        logic [MAC_W-1:0]  dest_mac;
        logic [MAC_W-1:0]  src_mac;
        logic [TYPE_W-1:0] eth_type;
    } eth_hdr_t;

    // index used to walk the input ports
    // the select port itself is sized from PORTS in each module
    typedef int unsigned port_idx_t;

endpackage

`default_nettype wire

// File: common/eth_stream_pkg.sv
// payload beat struct with data and keep widths
`default_nettype none

package eth_stream_pkg;

    // payload data width
    localparam int DATA_W = 64;

    // one byte enable per data byte
    localparam int KEEP_W = DATA_W / 8;

    // one payload beat, 74 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        // marks the final beat of a frame
        logic              last;
        // error flag carried with the beat
        logic              user;
    } eth_beat_t;

endpackage

`default_nettype wire

// File: eth_mux/eth_mux_core.sv
// frame-tracking port select, output header register and payload steering
`timescale 1ns/10ps
`default_nettype none

module eth_mux_core #(
    parameter int PORTS = 2
) (
    input  wire                        clk,
    input  wire                        rst,

    // control
    input  wire                        enable,
    input  wire [$clog2(PORTS)-1:0]    select,

    // per-port header streams
    input  wire eth_hdr_pkg::eth_hdr_t in_hdr [PORTS],
    input  wire                        in_hdr_valid [PORTS],
    output logic                       in_hdr_ready [PORTS],

    // per-port payload streams
    input  wire eth_stream_pkg::eth_beat_t in_beat [PORTS],
    input  wire                        in_beat_valid [PORTS],
    output logic                       in_beat_ready [PORTS],

    // header output driven straight from the local register
    output eth_hdr_pkg::eth_hdr_t      out_hdr,
    output logic                       out_hdr_valid,
    input  wire                        out_hdr_ready,

    // payload output toward the output slice
    output eth_stream_pkg::eth_beat_t  out_beat,
    output logic                       out_beat_valid,
    input  wire                        out_beat_ready
);

    import eth_hdr_pkg::*;
    import eth_stream_pkg::*;

    localparam int SEL_W = $clog2(PORTS);

    // port latched at frame start
    logic [SEL_W-1:0] sel_reg;
    // high from header accept until the last beat transfers
    logic             frame_reg;

    // header of the port named by select
    eth_hdr_t         pick_hdr;
    logic             pick_hdr_valid;

    // payload of the latched port
    eth_beat_t        cur_beat;
    logic             cur_valid;

    logic             hdr_take;
    logic             beat_xfer;

    // start-of-frame mux follows the live select input
    always_comb begin
        pick_hdr       = in_hdr[0];
        pick_hdr_valid = 1'b0;
        for (port_idx_t i = 0; i < PORTS; i++) begin
            if (select == SEL_W'(i)) begin
                pick_hdr       = in_hdr[i];
                pick_hdr_valid = in_hdr_valid[i];
            end
        end
    end

    // only start when idle and the previous header has left
    always_comb begin
        hdr_take = ~frame_reg & ~out_hdr_valid & enable & pick_hdr_valid;
        for (port_idx_t i = 0; i < PORTS; i++) begin
            in_hdr_ready[i] = hdr_take & (select == SEL_W'(i));
        end
    end

    // payload mux follows the latched port so select changes wait for the next frame
    always_comb begin
        cur_beat  = in_beat[0];
        cur_valid = 1'b0;
        for (port_idx_t i = 0; i < PORTS; i++) begin
            if (sel_reg == SEL_W'(i)) begin
                cur_beat  = in_beat[i];
                cur_valid = in_beat_valid[i];
            end
        end
    end

    always_comb begin
        out_beat       = cur_beat;
        out_beat_valid = frame_reg & cur_valid;
        // other ports stay stalled
        for (port_idx_t i = 0; i < PORTS; i++) begin
            in_beat_ready[i] = frame_reg & out_beat_ready & (sel_reg == SEL_W'(i));
        end
        beat_xfer = out_beat_valid & out_beat_ready;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_reg       <= '0;
            frame_reg     <= 1'b0;
            out_hdr_valid <= 1'b0;
        end else begin
            if (hdr_take) begin
                sel_reg       <= select;
                frame_reg     <= 1'b1;
                out_hdr_valid <= 1'b1;
            end else begin
                // frame closes on the edge its last beat moves
                if (beat_xfer & cur_beat.last) begin
                    frame_reg <= 1'b0;
                end
                if (out_hdr_ready) begin
                    out_hdr_valid <= 1'b0;
                end
            end
        end
    end

    // output header register is loaded once per frame
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            out_hdr <= pick_hdr;
        end
    end

endmodule

`default_nettype wire

// File: eth_mux_top.f
common/eth_hdr_pkg.sv
common/eth_stream_pkg.sv
rtl/stream_reg_slice.sv
eth_mux/eth_mux_core.sv
rtl/eth_mux_top.sv
test/tb_eth_mux_top.sv

// File: rtl/eth_mux_top.sv
// per-port input slices, mux core and payload output slice
`timescale 1ns/10ps
`default_nettype none

module eth_mux_top #(
    parameter int PORTS = 2
) (
    input  wire                            clk,
    input  wire                            rst,

    // input ports
    input  wire eth_hdr_pkg::eth_hdr_t     in_hdr [PORTS],
    input  wire                            in_hdr_valid [PORTS],
    output logic                           in_hdr_ready [PORTS],
    input  wire eth_stream_pkg::eth_beat_t in_beat [PORTS],
    input  wire                            in_beat_valid [PORTS],
    output logic                           in_beat_ready [PORTS],

    // output port
    output eth_hdr_pkg::eth_hdr_t          out_hdr,
    output logic                           out_hdr_valid,
    input  wire                            out_hdr_ready,
    output eth_stream_pkg::eth_beat_t      out_beat,
    output logic                           out_beat_valid,
    input  wire                            out_beat_ready,

    // control
    input  wire                            enable,
    input  wire [$clog2(PORTS)-1:0]        select
);

    import eth_hdr_pkg::*;
    import eth_stream_pkg::*;

    // between input slices and core
    eth_hdr_t  core_hdr [PORTS];
    logic      core_hdr_valid [PORTS];
    logic      core_hdr_ready [PORTS];
    eth_beat_t core_beat [PORTS];
    logic      core_beat_valid [PORTS];
    logic      core_beat_ready [PORTS];

    // between core and output slice
    eth_beat_t mux_beat;
    logic      mux_beat_valid;
    logic      mux_beat_ready;

    for (genvar p = 0; p < PORTS; p++) begin : g_in
        stream_reg_slice #(.T(eth_hdr_t)) u_hdr_slice (
            .clk     (clk),
            .rst     (rst),
            .s_data  (in_hdr[p]),
            .s_valid (in_hdr_valid[p]),
            .s_ready (in_hdr_ready[p]),
            .m_data  (core_hdr[p]),
            .m_valid (core_hdr_valid[p]),
            .m_ready (core_hdr_ready[p])
        );

        stream_reg_slice #(.T(eth_beat_t)) u_beat_slice (
            .clk     (clk),
            .rst     (rst),
            .s_data  (in_beat[p]),
            .s_valid (in_beat_valid[p]),
            .s_ready (in_beat_ready[p]),
            .m_data  (core_beat[p]),
            .m_valid (core_beat_valid[p]),
            .m_ready (core_beat_ready[p])
        );
    end

    eth_mux_core #(.PORTS(PORTS)) u_core (
        .clk            (clk),
        .rst            (rst),
        .enable         (enable),
        .select         (select),
        .in_hdr         (core_hdr),
        .in_hdr_valid   (core_hdr_valid),
        .in_hdr_ready   (core_hdr_ready),
        .in_beat        (core_beat),
        .in_beat_valid  (core_beat_valid),
        .in_beat_ready  (core_beat_ready),
        .out_hdr        (out_hdr),
        .out_hdr_valid  (out_hdr_valid),
        .out_hdr_ready  (out_hdr_ready),
        .out_beat       (mux_beat),
        .out_beat_valid (mux_beat_valid),
        .out_beat_ready (mux_beat_ready)
    );

    // only the payload leaves through one more slice
    stream_reg_slice #(.T(eth_beat_t)) u_out_slice (
        .clk     (clk),
        .rst     (rst),
        .s_data  (mux_beat),
        .s_valid (mux_beat_valid),
        .s_ready (mux_beat_ready),
        .m_data  (out_beat),
        .m_valid (out_beat_valid),
        .m_ready (out_beat_ready)
    );

endmodule

`default_nettype wire

// File: rtl/stream_reg_slice.sv
// valid/ready skid register with registered ready for any payload type
`timescale 1ns/10ps
`default_nettype none

module stream_reg_slice #(
    parameter type T = logic
) (
    input  wire  clk,
    input  wire  rst,

    // upstream side
    input  wire T s_data,
    input  wire  s_valid,
    output logic s_ready,

    // downstream side
    output T     m_data,
    output logic m_valid,
    input  wire  m_ready
);

    // second stage holds one item while the output is stalled
    T     tmp_data;
    logic tmp_valid;

    logic s_xfer;
    logic ready_early;

    always_comb begin
        s_xfer = s_valid & s_ready;
        // ready next cycle if the output drains or the temp register stays empty
        ready_early = m_ready | (~tmp_valid & (~m_valid | ~s_xfer));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_ready   <= 1'b0;
            m_valid   <= 1'b0;
            tmp_valid <= 1'b0;
        end else begin
            s_ready <= ready_early;
            if (s_ready) begin
                if (m_ready | ~m_valid) begin
                    m_valid <= s_valid;
                end else begin
                    // park the incoming item while the output is stalled
                    tmp_valid <= s_valid;
                end
            end else if (m_ready) begin
                // drain the temp register into the output
                m_valid   <= tmp_valid;
                tmp_valid <= 1'b0;
            end
        end
    end

    // payload registers follow the same steering as the valid bits
    always_ff @(posedge clk) begin
        if (s_ready) begin
            if (m_ready | ~m_valid) begin
                m_data <= s_data;
            end else begin
                tmp_data <= s_data;
            end
        end else if (m_ready) begin
            m_data <= tmp_data;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_eth_mux_top.sv
// random two-port frame stimulus, per-port queue model and output checks
`timescale 1ns/10ps
`default_nettype none

module tb_eth_mux_top;

    import eth_hdr_pkg::*;
    import eth_stream_pkg::*;

    localparam int PORTS     = 2;
    localparam int SEL_W     = $clog2(PORTS);
    localparam int N_FRAMES  = 60;
    // output frame counts where the select pattern changes
    localparam int SEL1_FROM = 15;
    localparam int MIX_FROM  = 30;
    localparam int LIMIT     = 200 * N_FRAMES + 1000;

    logic       clk;
    logic       rst;
    eth_hdr_t   in_hdr [PORTS];
    logic       in_hdr_valid [PORTS];
    logic       in_hdr_ready [PORTS];
    eth_beat_t  in_beat [PORTS];
    logic       in_beat_valid [PORTS];
    logic       in_beat_ready [PORTS];
    eth_hdr_t   out_hdr;
    logic       out_hdr_valid;
    logic       out_hdr_ready;
    eth_beat_t  out_beat;
    logic       out_beat_valid;
    logic       out_beat_ready;
    logic       enable;
    logic [SEL_W-1:0] select;

    integer     seed;

    // frames in send order with one queue set per port
    eth_hdr_t   sent_hdr [PORTS][$];
    int         sent_len [PORTS][$];
    eth_beat_t  sent_beat [PORTS][$];
    // frames opened at the output and not yet finished
    eth_hdr_t   exp_hdr [$];
    int         exp_len [$];
    eth_beat_t  exp_beat [$];

    int         opened;
    int         beats_out;
    int         beats_exp;
    int         frame_beats;
    int         mismatches;
    int         failures;
    logic       hdr_valid_q;
    logic       en_q;

    eth_mux_top #(.PORTS(PORTS)) uut (
        .clk            (clk),
        .rst            (rst),
        .in_hdr         (in_hdr),
        .in_hdr_valid   (in_hdr_valid),
        .in_hdr_ready   (in_hdr_ready),
        .in_beat        (in_beat),
        .in_beat_valid  (in_beat_valid),
        .in_beat_ready  (in_beat_ready),
        .out_hdr        (out_hdr),
        .out_hdr_valid  (out_hdr_valid),
        .out_hdr_ready  (out_hdr_ready),
        .out_beat       (out_beat),
        .out_beat_valid (out_beat_valid),
        .out_beat_ready (out_beat_ready),
        .enable         (enable),
        .select         (select)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic string phase_name();
        if (opened <= SEL1_FROM) return "select0";
        if (opened <= MIX_FROM) return "select1";
        return "mixed";
    endfunction

    // port for the next frame changes only right after an output header leaves
    function automatic logic [SEL_W-1:0] next_select();
        if (opened < SEL1_FROM) return '0;
        if (opened < MIX_FROM) return SEL_W'(1);
        return SEL_W'(rand_below(PORTS));
    endfunction

    task automatic random_gap();
        repeat ((rand_below(4) == 0) ? 1 + rand_below(3) : 0) @(posedge clk);
    endtask

    task automatic drive_port(input int p);
        eth_hdr_t  hdr;
        eth_beat_t beats [8];
        int        len;
        forever begin
            hdr.dest_mac = MAC_W'({$random(seed), $random(seed)});
            hdr.src_mac  = MAC_W'({$random(seed), $random(seed)});
            hdr.eth_type = TYPE_W'($random(seed));
            len = 1 + rand_below(8);
            for (int k = 0; k < len; k++) begin
                beats[k].data = {$random(seed), $random(seed)};
                beats[k].keep = KEEP_W'($random(seed));
                beats[k].last = (k == len - 1);
                beats[k].user = 1'($random(seed));
                sent_beat[p].push_back(beats[k]);
            end
            sent_hdr[p].push_back(hdr);
            sent_len[p].push_back(len);

            random_gap();
            in_hdr[p]       <= hdr;
            in_hdr_valid[p] <= 1'b1;
            @(posedge clk);
            while (!in_hdr_ready[p]) @(posedge clk);
            in_hdr_valid[p] <= 1'b0;

            for (int k = 0; k < len; k++) begin
                random_gap();
                in_beat[p]       <= beats[k];
                in_beat_valid[p] <= 1'b1;
                @(posedge clk);
                while (!in_beat_ready[p]) @(posedge clk);
                in_beat_valid[p] <= 1'b0;
            end
        end
    endtask

    for (genvar gp = 0; gp < PORTS; gp++) begin : g_drv
        initial begin
            wait (rst == 1'b0);
            @(posedge clk);
            drive_port(gp);
        end
    end

    task automatic check_reset_state();
        if (out_hdr_valid !== 1'b0 || out_beat_valid !== 1'b0) begin
            failures++;
            $display("output valid is not low during reset");
        end
        for (int p = 0; p < PORTS; p++) begin
            if (in_hdr_ready[p] !== 1'b0 || in_beat_ready[p] !== 1'b0) begin
                failures++;
                $display("input ready is high during reset on port %0d", p);
            end
        end
    endtask

    // the header just loaded in the core came from the port select named at that edge
    task automatic open_frame();
        int p;
        int len;
        p = int'(select);
        if (!en_q) begin
            failures++;
            $display("a new output header started while enable was low");
        end
        if (sent_hdr[p].size() == 0) begin
            failures++;
            $display("output header appeared with no frame queued on port %0d", p);
        end else begin
            exp_hdr.push_back(sent_hdr[p].pop_front());
            len = sent_len[p].pop_front();
            exp_len.push_back(len);
            beats_exp += len;
            repeat (len) exp_beat.push_back(sent_beat[p].pop_front());
        end
        opened++;
    endtask

    task automatic check_header();
        eth_hdr_t exp;
        if (exp_hdr.size() == 0) begin
            failures++;
            $display("output header transfer with no header expected");
        end else begin
            exp = exp_hdr.pop_front();
            if (out_hdr !== exp) begin
                mismatches++;
                $display("mismatch %s header: expected %h actual %h", phase_name(), exp, out_hdr);
            end
        end
    endtask

    task automatic check_beat();
        eth_beat_t exp;
        int        len;
        beats_out++;
        frame_beats++;
        if (exp_beat.size() == 0) begin
            failures++;
            $display("payload beat arrived outside any open frame");
        end else begin
            exp = exp_beat.pop_front();
            if (out_beat !== exp) begin
                mismatches++;
                $display("mismatch %s beat: expected %h actual %h", phase_name(), exp, out_beat);
            end
        end
        if (out_beat.last && exp_len.size() != 0) begin
            len = exp_len.pop_front();
            if (frame_beats != len) begin
                mismatches++;
                $display("mismatch %s frame length: expected %0d actual %0d",
                         phase_name(), len, frame_beats);
            end
            frame_beats = 0;
        end
    endtask

    // registered DUT outputs sampled at the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (out_hdr_valid && !hdr_valid_q) open_frame();
            if (out_hdr_valid && out_hdr_ready) begin
                check_header();
                select <= next_select();
            end
            if (out_beat_valid && out_beat_ready) check_beat();
            hdr_valid_q = out_hdr_valid;
            en_q        = enable;
            out_hdr_ready  <= (rand_below(4) != 0);
            out_beat_ready <= (rand_below(4) != 0);
            // enable drops for good once enough frames are open and toggles in the mixed phase
            if (opened >= N_FRAMES) begin
                enable <= 1'b0;
            end else if (opened >= MIX_FROM && rand_below(12) == 0) begin
                enable <= ~enable;
            end
        end
    end

    initial begin
        seed           = 32'he6fd_5be7;
        rst            = 1'b1;
        enable         = 1'b1;
        select         = '0;
        out_hdr_ready  = 1'b0;
        out_beat_ready = 1'b0;
        for (int p = 0; p < PORTS; p++) begin
            in_hdr[p]        = '0;
            in_hdr_valid[p]  = 1'b0;
            in_beat[p]       = '0;
            in_beat_valid[p] = 1'b0;
        end
        opened      = 0;
        beats_out   = 0;
        beats_exp   = 0;
        frame_beats = 0;
        mismatches  = 0;
        failures    = 0;
        hdr_valid_q = 1'b0;
        en_q        = 1'b0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        while (!(opened >= N_FRAMES && exp_hdr.size() == 0 && exp_beat.size() == 0)) begin
            @(negedge clk);
        end
        // idle time to catch stray headers or beats
        repeat (20) @(posedge clk);
        @(negedge clk);
        if (beats_out != beats_exp) begin
            mismatches++;
            $display("mismatch total beats: expected %0d actual %0d", beats_exp, beats_out);
        end
        if (frame_beats != 0) begin
            failures++;
            $display("the last output frame never ended with last");
        end
        $display("tb_eth_mux_top: %0d mismatches, %0d other failures, %0d frames, %0d beats",
                 mismatches, failures, opened, beats_out);
        if (mismatches == 0 && failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
